// File: files.f
+incdir+.
mcalc_pkg.sv
uart_rx.sv
uart_tx.sv
main_fsm.sv
matrix_input.sv
matrix_store.sv
matrix_alu.sv
system_core.sv
tb_system_core.sv

// File: Makefile
# Verilator build and run of the matrix calculator testbench

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check sim.log"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_system_core -f files.f
	./obj_dir/Vtb_system_core > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "TEST FAILED"; exit 1; fi
	@grep -q "Simulation passed" sim.log || (echo "TEST FAILED"; exit 1)
	@echo "TEST PASSED"

clean:
	rm -rf obj_dir sim.log

// File: tb_system_core.sv
// Random-stimulus testbench for the matrix calculator; drives UART frames and buttons, checks results
`default_nettype none
`include "mcalc_cfg.svh"

module tb_system_core import mcalc_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int BIT_CLKS   = `MCALC_CLKS_PER_BIT;
  localparam int MAX_CYCLES = 200000;

  logic        clk;
  logic        rst_n;
  logic        uart_rx;
  logic [7:0]  sw_mode_sel;
  logic [7:0]  sw_scalar_val;
  logic        btn_confirm;
  logic        btn_reset_logic;
  logic        uart_tx;
  logic [15:0] led_status;

  int          seed = 32'h6a3f8fdb;
  int          cycles = 0;
  logic [7:0]  rx_q [$];
  logic [7:0]  exp_q [$];

  // Reference copy of the slot store
  logic [7:0]               m_mem [`MCALC_NUM_SLOTS][`MCALC_MAX_DIM][`MCALC_MAX_DIM];
  int                       m_rows [`MCALC_NUM_SLOTS];
  int                       m_cols [`MCALC_NUM_SLOTS];
  logic [`MCALC_SLOT_W-1:0] next_slot;

  system_core system_core_i (
    .clk(clk), .rst_n(rst_n), .uart_rx(uart_rx), .sw_mode_sel(sw_mode_sel),
    .sw_scalar_val(sw_scalar_val), .btn_confirm(btn_confirm),
    .btn_reset_logic(btn_reset_logic), .uart_tx(uart_tx), .led_status(led_status)
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: no end of test within %0d clock cycles", MAX_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  // ==================================================
  // Helpers
  // ==================================================
  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Next drive point, just after the rising edge
  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  function automatic int rand_dim();
    return ($unsigned($random(seed)) % `MCALC_MAX_DIM) + 1;
  endfunction

  // One 8N1 frame, LSB first
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (BIT_CLKS) tick();
    end
  endtask

  // Mid-bit sampler for the DUT output line
  task automatic collect_tx_bytes();
    logic [7:0] b;
    forever begin
      @(negedge uart_tx);
      repeat (BIT_CLKS / 2) @(negedge clk);
      check("uart_tx start bit", uart_tx, 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        b[i] = uart_tx;
      end
      repeat (BIT_CLKS) @(negedge clk);
      check("uart_tx stop bit", uart_tx, 1'b1);
      rx_q.push_back(b);
    end
  endtask

  task automatic press_confirm(input logic [7:0] sw);
    sw_mode_sel = sw;
    btn_confirm = 1'b1;
    tick();
    btn_confirm = 1'b0;
    tick();
  endtask

  // Returns sampling at a falling edge
  task automatic wait_idle();
    @(negedge clk);
    while (!led_status[0]) begin
      @(negedge clk);
    end
  endtask

  // Header bytes then random elements, mirrored into the model slot
  task automatic send_matrix(input int rows, input int cols, output logic [1:0] slot);
    logic [7:0] v;
    slot = next_slot;
    send_byte(8'(rows));
    send_byte(8'(cols));
    for (int r = 0; r < rows; r++) begin
      for (int c = 0; c < cols; c++) begin
        v = 8'($random(seed));
        m_mem[slot][r][c] = v;
        send_byte(v);
      end
    end
    m_rows[slot] = rows;
    m_cols[slot] = cols;
    next_slot = next_slot + 1'b1;
  endtask

  task automatic enter_matrix(input int rows, input int cols, input logic [15:0] led_exp,
                              output logic [1:0] slot);
    press_confirm(8'h01);
    send_matrix(rows, cols, slot);
    wait_idle();
    check("led_status", led_status, led_exp);
    tick();
  endtask

  // Output is A cols by A rows
  task automatic expect_transpose(input logic [1:0] a);
    for (int r = 0; r < m_cols[a]; r++) begin
      for (int c = 0; c < m_rows[a]; c++) begin
        exp_q.push_back(m_mem[a][c][r]);
      end
    end
  endtask

  // Sum, difference or scaled A, low 8 bits kept
  task automatic expect_elementwise(input op_code_t op, input logic [1:0] a,
                                    input logic [1:0] b, input logic [7:0] s);
    logic [7:0] x;
    for (int r = 0; r < m_rows[a]; r++) begin
      for (int c = 0; c < m_cols[a]; c++) begin
        case (op)
          OP_ADD:  x = m_mem[a][r][c] + m_mem[b][r][c];
          OP_SUB:  x = m_mem[a][r][c] - m_mem[b][r][c];
          default: x = m_mem[a][r][c] * s;
        endcase
        exp_q.push_back(x);
      end
    end
  endtask

  // Calc mode, then opcode and slot ids on the second confirm
  task automatic start_calc(input op_code_t op, input logic [1:0] a, input logic [1:0] b);
    rx_q.delete();
    press_confirm(8'h02);
    check("led_status[2:0]", led_status[2:0], 3'b100);
    press_confirm({b, a, op, 2'b10});
  endtask

  task automatic finish_calc(input logic [15:0] led_exp);
    wait_idle();
    repeat (4) @(negedge clk);
    check("led_status", led_status, led_exp);
    check("result byte count", rx_q.size(), exp_q.size());
    foreach (exp_q[i]) begin
      check("uart_tx byte", rx_q[i], exp_q[i]);
    end
    exp_q.delete();
    tick();
  endtask

  initial begin : monitor
    wait (rst_n === 1'b1);
    collect_tx_bytes();
  end

  // ==================================================
  // Test sequence
  // ==================================================
  initial begin : stimulus
    logic [1:0] slots [4];
    logic [1:0] sa;
    logic [1:0] sb;
    logic [7:0] scale;
    int         r;
    int         c;
    rst_n           = 1'b0;
    uart_rx         = 1'b1;
    sw_mode_sel     = 8'h00;
    sw_scalar_val   = 8'h00;
    btn_confirm     = 1'b0;
    btn_reset_logic = 1'b0;
    next_slot       = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check("led_status", led_status, 16'h0001);
    check("uart_tx", uart_tx, 1'b1);
    tick();

    // Four matrices, then transpose of each slot
    for (int i = 0; i < 4; i++) begin
      enter_matrix(rand_dim(), rand_dim(), 16'h0001, slots[i]);
    end
    for (int i = 0; i < 4; i++) begin
      expect_transpose(slots[i]);
      start_calc(OP_TRANS, slots[i], slots[i]);
      finish_calc(16'h0001);
    end

    // Add and subtract on fresh pairs of equal shape
    for (int i = 0; i < 2; i++) begin
      r = rand_dim();
      c = rand_dim();
      enter_matrix(r, c, 16'h0001, sa);
      enter_matrix(r, c, 16'h0001, sb);
      expect_elementwise(OP_ADD, sa, sb, 8'h00);
      start_calc(OP_ADD, sa, sb);
      finish_calc(16'h0001);
      expect_elementwise(OP_SUB, sa, sb, 8'h00);
      start_calc(OP_SUB, sa, sb);
      finish_calc(16'h0001);
    end

    // Shape mismatch, row counts always differ
    r = rand_dim();
    enter_matrix(r, rand_dim(), 16'h0001, sa);
    enter_matrix(r % `MCALC_MAX_DIM + 1, rand_dim(), 16'h0001, sb);
    start_calc(OP_ADD, sa, sb);
    finish_calc(16'h8001);
    repeat (BIT_CLKS * 12) @(negedge clk);
    check("byte count after calc error", rx_q.size(), 0);
    tick();

    // Scalar multiply, calc error flag drops at the start
    scale = 8'($random(seed));
    sw_scalar_val = scale;
    expect_elementwise(OP_SCALE, sa, sa, scale);
    start_calc(OP_SCALE, sa, sa);
    @(negedge clk);
    check("led_status[15]", led_status[15], 1'b0);
    finish_calc(16'h0001);

    // Bad row count, then a good matrix in the same session
    press_confirm(8'h01);
    send_byte(($random(seed) & 1) ? 8'd5 : 8'd0);
    @(negedge clk);
    check("led_status", led_status, 16'h4002);
    tick();
    send_matrix(rand_dim(), rand_dim(), sa);
    wait_idle();
    check("led_status", led_status, 16'h4001);
    tick();
    expect_transpose(sa);
    start_calc(OP_TRANS, sa, sa);
    finish_calc(16'h4001);

    // Input error clears on the next entry, Esc leaves input mode
    press_confirm(8'h01);
    check("led_status", led_status, 16'h0002);
    btn_reset_logic = 1'b1;
    tick();
    btn_reset_logic = 1'b0;
    wait_idle();
    check("led_status", led_status, 16'h0001);

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: system_core.sv
// Top level of the matrix calculator joining UART, mode FSM, parser, store, ALU and LEDs
`default_nettype none
`include "mcalc_cfg.svh"

module system_core import mcalc_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        uart_rx,
  input  logic [7:0]  sw_mode_sel,
  input  logic [7:0]  sw_scalar_val,
  input  logic        btn_confirm,
  input  logic        btn_reset_logic,
  output logic        uart_tx,
  output logic [15:0] led_status
);

  // ==================================================
  // Interconnect
  // ==================================================
  sys_state_t                 state;
  logic                       input_en, input_en_q;
  logic                       rx_valid;
  logic [7:0]                 rx_byte;
  logic                       tx_start, tx_busy;
  logic [7:0]                 tx_byte;
  logic                       calc_go, calc_done, calc_err;
  logic                       input_done, input_err;
  logic                       in_err_q, calc_err_q;
  // Store write side
  logic                       wr_new, wr_en;
  logic [`MCALC_DIM_W-1:0]    wr_rows, wr_cols, wr_row, wr_col;
  matrix_element_t            wr_data;
  // Store read side
  logic [`MCALC_SLOT_W-1:0]   rd_id_a, rd_id_b;
  logic [`MCALC_DIM_W-1:0]    rd_row, rd_col;
  matrix_element_t            rd_data_a, rd_data_b;
  logic [`MCALC_DIM_W-1:0]    a_rows, a_cols, b_rows, b_cols;
  logic                       a_valid, b_valid;

  assign input_en = (state == STATE_INPUT);

  uart_rx uart_rx_i (
    .clk(clk), .rst_n(rst_n), .rxd(uart_rx), .rx_valid(rx_valid), .rx_byte(rx_byte)
  );

  uart_tx uart_tx_i (
    .clk(clk), .rst_n(rst_n), .tx_start(tx_start), .tx_byte(tx_byte),
    .txd(uart_tx), .tx_busy(tx_busy)
  );

  // Esc button doubles as the logic reset
  main_fsm main_fsm_i (
    .clk(clk), .rst_n(rst_n), .sw_mode_sel(sw_mode_sel), .btn_confirm(btn_confirm),
    .btn_esc(btn_reset_logic), .input_done(input_done), .calc_done(calc_done),
    .state(state), .calc_go(calc_go)
  );

  matrix_input matrix_input_i (
    .clk(clk), .rst_n(rst_n), .input_en(input_en), .rx_valid(rx_valid), .rx_byte(rx_byte),
    .wr_new(wr_new), .wr_rows(wr_rows), .wr_cols(wr_cols), .wr_en(wr_en),
    .wr_row(wr_row), .wr_col(wr_col), .wr_data(wr_data),
    .input_done(input_done), .input_err(input_err)
  );

  matrix_store matrix_store_i (
    .clk(clk), .rst_n(rst_n), .wr_new(wr_new), .wr_rows(wr_rows), .wr_cols(wr_cols),
    .wr_en(wr_en), .wr_row(wr_row), .wr_col(wr_col), .wr_data(wr_data),
    .rd_id_a(rd_id_a), .rd_id_b(rd_id_b), .rd_row(rd_row), .rd_col(rd_col),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .a_rows(a_rows), .a_cols(a_cols),
    .a_valid(a_valid), .b_rows(b_rows), .b_cols(b_cols), .b_valid(b_valid),
    .last_wr_id()
  );

  // Opcode on bits 3:2, slot A on 5:4, slot B on 7:6
  matrix_alu matrix_alu_i (
    .clk(clk), .rst_n(rst_n), .calc_go(calc_go), .op_code(op_code_t'(sw_mode_sel[3:2])),
    .id_a(sw_mode_sel[5:4]), .id_b(sw_mode_sel[7:6]),
    .scalar_val(matrix_element_t'(sw_scalar_val)),
    .rd_data_a(rd_data_a), .rd_data_b(rd_data_b), .a_rows(a_rows), .a_cols(a_cols),
    .a_valid(a_valid), .b_rows(b_rows), .b_cols(b_cols), .b_valid(b_valid),
    .tx_busy(tx_busy), .rd_id_a(rd_id_a), .rd_id_b(rd_id_b), .rd_row(rd_row),
    .rd_col(rd_col), .tx_start(tx_start), .tx_byte(tx_byte),
    .calc_done(calc_done), .calc_err(calc_err)
  );

  // ==================================================
  // Sticky error flags
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      input_en_q <= 1'b0;
      in_err_q   <= 1'b0;
      calc_err_q <= 1'b0;
    end else begin
      input_en_q <= input_en;
      // Input error clears on entry to input mode
      if (input_err) in_err_q <= 1'b1;
      else if (input_en && !input_en_q) in_err_q <= 1'b0;
      // Calc error clears at the next start
      if (calc_done && calc_err) calc_err_q <= 1'b1;
      else if (calc_go) calc_err_q <= 1'b0;
    end
  end

  // Errors on 15 and 14, one-hot state on 2:0
  assign led_status = {calc_err_q, in_err_q, 11'd0,
                       state == STATE_CALC, state == STATE_INPUT, state == STATE_IDLE};

endmodule

`default_nettype wire

// File: matrix_alu.sv
// Matrix ALU that walks result indices and streams one result byte per element to the UART
`default_nettype none
`include "mcalc_cfg.svh"

module matrix_alu import mcalc_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     calc_go,
  input  op_code_t                 op_code,
  input  logic [`MCALC_SLOT_W-1:0] id_a,
  input  logic [`MCALC_SLOT_W-1:0] id_b,
  input  matrix_element_t          scalar_val,
  input  matrix_element_t          rd_data_a,
  input  matrix_element_t          rd_data_b,
  input  logic [`MCALC_DIM_W-1:0]  a_rows,
  input  logic [`MCALC_DIM_W-1:0]  a_cols,
  input  logic                     a_valid,
  input  logic [`MCALC_DIM_W-1:0]  b_rows,
  input  logic [`MCALC_DIM_W-1:0]  b_cols,
  input  logic                     b_valid,
  input  logic                     tx_busy,
  output logic [`MCALC_SLOT_W-1:0] rd_id_a,
  output logic [`MCALC_SLOT_W-1:0] rd_id_b,
  output logic [`MCALC_DIM_W-1:0]  rd_row,
  output logic [`MCALC_DIM_W-1:0]  rd_col,
  output logic                     tx_start,
  output logic [7:0]               tx_byte,
  output logic                     calc_done,
  output logic                     calc_err
);

  localparam int DW = `MCALC_DIM_W;
  localparam logic [DW-1:0] ONE = DW'(1);

  typedef enum logic [1:0] {ALU_IDLE, ALU_CHECK, ALU_SEND, ALU_WAIT} alu_state_t;

  alu_state_t      alu_state;
  op_code_t        op_q;
  matrix_element_t scalar_q;
  matrix_element_t result;
  logic [DW-1:0]   out_rows;
  logic [DW-1:0]   out_cols;
  logic [DW-1:0]   row_q;
  logic [DW-1:0]   col_q;
  logic            bad_dims;
  logic            last_elem;

  // Transpose reads A at the swapped index
  assign rd_row = (op_q == OP_TRANS) ? col_q : row_q;
  assign rd_col = (op_q == OP_TRANS) ? row_q : col_q;

  // A always needed, B only for add and subtract with matching shape
  assign bad_dims = !a_valid ||
                    ((op_q == OP_ADD || op_q == OP_SUB) &&
                     (!b_valid || a_rows != b_rows || a_cols != b_cols));

  assign last_elem = (row_q == out_rows - ONE) && (col_q == out_cols - ONE);

  // Element result, wraps to 8 bits
  always_comb begin
    case (op_q)
      OP_ADD:   result = rd_data_a + rd_data_b;
      OP_SUB:   result = rd_data_a - rd_data_b;
      OP_SCALE: result = rd_data_a * scalar_q;
      default:  result = rd_data_a;
    endcase
  end

  // ==================================================
  // Operation sequencing
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      alu_state <= ALU_IDLE;
      op_q      <= OP_ADD;
      rd_id_a   <= '0;
      rd_id_b   <= '0;
      row_q     <= '0;
      col_q     <= '0;
      tx_start  <= 1'b0;
      calc_done <= 1'b0;
      calc_err  <= 1'b0;
    end else begin
      tx_start  <= 1'b0;
      calc_done <= 1'b0;
      case (alu_state)
        ALU_IDLE: begin
          // Operands latched off the switches
          if (calc_go) begin
            op_q      <= op_code;
            rd_id_a   <= id_a;
            rd_id_b   <= id_b;
            calc_err  <= 1'b0;
            alu_state <= ALU_CHECK;
          end
        end
        ALU_CHECK: begin
          row_q <= '0;
          col_q <= '0;
          if (bad_dims) begin
            calc_done <= 1'b1;
            calc_err  <= 1'b1;
            alu_state <= ALU_IDLE;
          end else begin
            alu_state <= ALU_SEND;
          end
        end
        ALU_SEND: begin
          // Hold the byte until the transmitter is free
          if (!tx_busy) begin
            tx_start  <= 1'b1;
            alu_state <= ALU_WAIT;
          end
        end
        default: begin
          // Busy rises a cycle after the strobe, so skip that cycle
          if (!tx_start && !tx_busy) begin
            if (last_elem) begin
              calc_done <= 1'b1;
              alu_state <= ALU_IDLE;
            end else if (col_q == out_cols - ONE) begin
              col_q     <= '0;
              row_q     <= row_q + ONE;
              alu_state <= ALU_SEND;
            end else begin
              col_q     <= col_q + ONE;
              alu_state <= ALU_SEND;
            end
          end
        end
      endcase
    end
  end

  // Scalar, output shape and byte payload
  always_ff @(posedge clk) begin
    if (alu_state == ALU_IDLE && calc_go) scalar_q <= scalar_val;
    if (alu_state == ALU_CHECK) begin
      out_rows <= (op_q == OP_TRANS) ? a_cols : a_rows;
      out_cols <= (op_q == OP_TRANS) ? a_rows : a_cols;
    end
    if (alu_state == ALU_SEND && !tx_busy) tx_byte <= result;
  end

endmodule

`default_nettype wire

// File: matrix_store.sv
// Slot store of matrices with one write port and two combinational read ports for the ALU
`default_nettype none
`include "mcalc_cfg.svh"

module matrix_store import mcalc_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wr_new,
  input  logic [`MCALC_DIM_W-1:0]  wr_rows,
  input  logic [`MCALC_DIM_W-1:0]  wr_cols,
  input  logic                     wr_en,
  input  logic [`MCALC_DIM_W-1:0]  wr_row,
  input  logic [`MCALC_DIM_W-1:0]  wr_col,
  input  matrix_element_t          wr_data,
  input  logic [`MCALC_SLOT_W-1:0] rd_id_a,
  input  logic [`MCALC_SLOT_W-1:0] rd_id_b,
  input  logic [`MCALC_DIM_W-1:0]  rd_row,
  input  logic [`MCALC_DIM_W-1:0]  rd_col,
  output matrix_element_t          rd_data_a,
  output matrix_element_t          rd_data_b,
  output logic [`MCALC_DIM_W-1:0]  a_rows,
  output logic [`MCALC_DIM_W-1:0]  a_cols,
  output logic                     a_valid,
  output logic [`MCALC_DIM_W-1:0]  b_rows,
  output logic [`MCALC_DIM_W-1:0]  b_cols,
  output logic                     b_valid,
  output logic [`MCALC_SLOT_W-1:0] last_wr_id
);

  localparam int N  = `MCALC_NUM_SLOTS;
  localparam int M  = `MCALC_MAX_DIM;
  localparam int IW = $clog2(`MCALC_MAX_DIM);
  localparam int SW = `MCALC_SLOT_W;

  matrix_element_t           mem [N][M][M];
  logic [`MCALC_DIM_W-1:0]   rows_q [N];
  logic [`MCALC_DIM_W-1:0]   cols_q [N];
  logic [N-1:0]              valid_q;
  logic [SW-1:0]             next_id;

  // Slot headers, round-robin claim from slot 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '0;
      next_id    <= '0;
      last_wr_id <= '0;
      for (int i = 0; i < N; i++) begin
        rows_q[i] <= '0;
        cols_q[i] <= '0;
      end
    end else if (wr_new) begin
      valid_q[next_id] <= 1'b1;
      rows_q[next_id]  <= wr_rows;
      cols_q[next_id]  <= wr_cols;
      last_wr_id       <= next_id;
      next_id          <= (next_id == SW'(N - 1)) ? '0 : next_id + 1'b1;
    end
  end

  // Elements go to the slot claimed last
  always_ff @(posedge clk) begin
    if (wr_en) mem[last_wr_id][wr_row[IW-1:0]][wr_col[IW-1:0]] <= wr_data;
  end

  // Read ports
  assign rd_data_a = mem[rd_id_a][rd_row[IW-1:0]][rd_col[IW-1:0]];
  assign rd_data_b = mem[rd_id_b][rd_row[IW-1:0]][rd_col[IW-1:0]];
  assign a_rows    = rows_q[rd_id_a];
  assign a_cols    = cols_q[rd_id_a];
  assign a_valid   = valid_q[rd_id_a];
  assign b_rows    = rows_q[rd_id_b];
  assign b_cols    = cols_q[rd_id_b];
  assign b_valid   = valid_q[rd_id_b];

  // Parser indices stay inside the dimensions it claimed
  assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> (valid_q[last_wr_id] && wr_row < rows_q[last_wr_id]
               && wr_col < cols_q[last_wr_id]))
    else $error("element write outside claimed matrix");

endmodule

`default_nettype wire

// File: matrix_input.sv
// Parses received bytes into a matrix and writes it element by element into the slot store
`default_nettype none
`include "mcalc_cfg.svh"

module matrix_input import mcalc_pkg::*; (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    input_en,
  input  logic                    rx_valid,
  input  logic [7:0]              rx_byte,
  output logic                    wr_new,
  output logic [`MCALC_DIM_W-1:0] wr_rows,
  output logic [`MCALC_DIM_W-1:0] wr_cols,
  output logic                    wr_en,
  output logic [`MCALC_DIM_W-1:0] wr_row,
  output logic [`MCALC_DIM_W-1:0] wr_col,
  output matrix_element_t         wr_data,
  output logic                    input_done,
  output logic                    input_err
);

  localparam int DW = `MCALC_DIM_W;
  localparam logic [DW-1:0] ONE = DW'(1);

  typedef enum logic [1:0] {PH_ROWS, PH_COLS, PH_ELEM} phase_t;

  phase_t          phase;
  logic [DW-1:0]   rows_q;
  logic [DW-1:0]   cols_q;
  logic [DW-1:0]   row_q;
  logic [DW-1:0]   col_q;
  logic            last_q;
  logic            dim_ok;

  // Legal dimension byte, 1 to max
  assign dim_ok = (rx_byte != 8'd0) && (rx_byte <= 8'(`MCALC_MAX_DIM));

  // ==================================================
  // Phase control and strobes
  // ==================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase      <= PH_ROWS;
      row_q      <= '0;
      col_q      <= '0;
      wr_new     <= 1'b0;
      wr_en      <= 1'b0;
      last_q     <= 1'b0;
      input_done <= 1'b0;
      input_err  <= 1'b0;
    end else begin
      wr_new     <= 1'b0;
      wr_en      <= 1'b0;
      last_q     <= 1'b0;
      input_err  <= 1'b0;
      // Done follows the final write by one cycle
      input_done <= last_q;
      if (!input_en) begin
        // Leaving input mode drops a partial matrix
        phase <= PH_ROWS;
      end else if (rx_valid) begin
        case (phase)
          PH_ROWS: begin
            if (dim_ok) phase <= PH_COLS;
            else input_err <= 1'b1;
          end
          PH_COLS: begin
            if (dim_ok) begin
              phase  <= PH_ELEM;
              wr_new <= 1'b1;
              row_q  <= '0;
              col_q  <= '0;
            end else begin
              input_err <= 1'b1;
              phase     <= PH_ROWS;
            end
          end
          default: begin
            // Row-major walk over the elements
            wr_en <= 1'b1;
            if (col_q == cols_q - ONE) begin
              col_q <= '0;
              if (row_q == rows_q - ONE) begin
                last_q <= 1'b1;
                phase  <= PH_ROWS;
              end else begin
                row_q <= row_q + ONE;
              end
            end else begin
              col_q <= col_q + ONE;
            end
          end
        endcase
      end
    end
  end

  // Dimensions and write payload
  always_ff @(posedge clk) begin
    if (rx_valid && phase == PH_ROWS) rows_q <= rx_byte[DW-1:0];
    if (rx_valid && phase == PH_COLS) begin
      cols_q  <= rx_byte[DW-1:0];
      wr_rows <= rows_q;
      wr_cols <= rx_byte[DW-1:0];
    end
    if (rx_valid && phase == PH_ELEM) begin
      wr_row  <= row_q;
      wr_col  <= col_q;
      wr_data <= matrix_element_t'(rx_byte);
    end
  end

endmodule

`default_nettype wire

// File: main_fsm.sv
// Mode FSM choosing input or calculation from the switches and the confirm and Esc buttons
`default_nettype none

module main_fsm import mcalc_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [7:0] sw_mode_sel,
  input  logic       btn_confirm,
  input  logic       btn_esc,
  input  logic       input_done,
  input  logic       calc_done,
  output sys_state_t state,
  output logic       calc_go
);

  // ALU operation in flight
  logic running;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= STATE_IDLE;
      calc_go <= 1'b0;
      running <= 1'b0;
    end else begin
      calc_go <= 1'b0;
      case (state)
        STATE_IDLE: begin
          // Mode bits 1:0, 01 input and 10 calc
          if (btn_confirm) begin
            if (sw_mode_sel[1:0] == 2'b01) state <= STATE_INPUT;
            else if (sw_mode_sel[1:0] == 2'b10) state <= STATE_CALC;
          end
        end
        STATE_INPUT: begin
          if (input_done || btn_esc) state <= STATE_IDLE;
        end
        STATE_CALC: begin
          if (running) begin
            // Esc ignored until the ALU reports back
            if (calc_done) begin
              running <= 1'b0;
              state   <= STATE_IDLE;
            end
          end else if (btn_confirm) begin
            calc_go <= 1'b1;
            running <= 1'b1;
          end else if (btn_esc) begin
            state <= STATE_IDLE;
          end
        end
        default: state <= STATE_IDLE;
      endcase
    end
  end

  // Start strobe only inside calc mode with the run flag set
  assert property (@(posedge clk) disable iff (!rst_n)
    calc_go |-> (state == STATE_CALC && running))
    else $error("calc_go outside STATE_CALC");

endmodule

`default_nettype wire

// File: uart_tx.sv
// UART transmitter sending one 8N1 frame per start strobe for the ALU result stream
`default_nettype none
`include "mcalc_cfg.svh"

module uart_tx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       tx_start,
  input  logic [7:0] tx_byte,
  output logic       txd,
  output logic       tx_busy
);

  localparam int CNT_W = $clog2(`MCALC_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(`MCALC_CLKS_PER_BIT - 1);

  logic [9:0]       frame_q;
  logic [3:0]       bit_cnt;
  logic [CNT_W-1:0] div_cnt;

  // Idle line is high
  assign txd = tx_busy ? frame_q[0] : 1'b1;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_busy <= 1'b0;
      bit_cnt <= '0;
      div_cnt <= '0;
    end else if (tx_start && !tx_busy) begin
      tx_busy <= 1'b1;
      bit_cnt <= '0;
      div_cnt <= '0;
    end else if (tx_busy) begin
      // Ten bit periods, start through stop
      if (div_cnt == FULL) begin
        div_cnt <= '0;
        if (bit_cnt == 4'd9) tx_busy <= 1'b0;
        else bit_cnt <= bit_cnt + 1'b1;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

  // Frame shifts out LSB first, stop bit on top
  always_ff @(posedge clk) begin
    if (tx_start && !tx_busy) frame_q <= {1'b1, tx_byte, 1'b0};
    else if (tx_busy && div_cnt == FULL) frame_q <= {1'b1, frame_q[9:1]};
  end

  // Sender must wait out the frame in flight
  assert property (@(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy)
    else $error("tx_start while tx_busy");

endmodule

`default_nettype wire

// File: uart_rx.sv
// UART receiver for 8N1 frames, strobing each good byte into the input parser
`default_nettype none
`include "mcalc_cfg.svh"

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rxd,
  output logic       rx_valid,
  output logic [7:0] rx_byte
);

  localparam int CNT_W = $clog2(`MCALC_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] FULL = CNT_W'(`MCALC_CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'(`MCALC_CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

  rx_state_t        rx_state;
  logic [1:0]       sync_q;
  logic             rxd_s;
  logic [CNT_W-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  logic [7:0]       shift_q;

  // Line after the two-flop synchronizer
  assign rxd_s = sync_q[1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q   <= 2'b11;
      rx_state <= RX_IDLE;
      div_cnt  <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      sync_q   <= {sync_q[0], rxd};
      rx_valid <= 1'b0;
      case (rx_state)
        RX_IDLE: begin
          // Falling edge opens a frame
          div_cnt <= '0;
          if (!rxd_s) rx_state <= RX_START;
        end
        RX_START: begin
          // Half a bit to the middle of the start bit, glitch check there
          if (div_cnt == HALF) begin
            div_cnt  <= '0;
            bit_cnt  <= '0;
            rx_state <= rxd_s ? RX_IDLE : RX_DATA;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (div_cnt == FULL) begin
            div_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) rx_state <= RX_STOP;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
        default: begin
          // Middle of stop bit, low stop drops the frame
          if (div_cnt == FULL) begin
            rx_valid <= rxd_s;
            rx_state <= RX_IDLE;
          end else begin
            div_cnt <= div_cnt + 1'b1;
          end
        end
      endcase
    end
  end

  // Data bits, LSB first, sampled mid-bit
  always_ff @(posedge clk) begin
    if (rx_state == RX_DATA && div_cnt == FULL) shift_q <= {rxd_s, shift_q[7:1]};
    if (rx_state == RX_STOP && div_cnt == FULL) rx_byte <= shift_q;
  end

  // Byte strobe is a single cycle wide
  assert property (@(posedge clk) disable iff (!rst_n) rx_valid |=> !rx_valid)
    else $error("rx_valid held for two cycles");

endmodule

`default_nettype wire

// File: mcalc_pkg.sv
// Shared types of the matrix calculator, imported by the FSM, parser, store, ALU and top
`default_nettype none

package mcalc_pkg;

  // ==================================================
  // Top level modes
  // ==================================================
  typedef enum logic [1:0] {
    STATE_IDLE  = 2'd0,
    STATE_INPUT = 2'd1,
    STATE_CALC  = 2'd2
  } sys_state_t;

  // ALU operations, encoded as switch bits 3:2
  typedef enum logic [1:0] {
    OP_ADD   = 2'd0,
    OP_SUB   = 2'd1,
    OP_SCALE = 2'd2,
    OP_TRANS = 2'd3
  } op_code_t;

  // One matrix element, two's complement
  typedef logic signed [7:0] matrix_element_t;

endpackage

`default_nettype wire

// File: mcalc_cfg.svh
// Build-time sizes of the matrix calculator, included by the RTL and the testbench
`ifndef MCALC_CFG_SVH
`define MCALC_CFG_SVH

// ==================================================
// UART timing
// ==================================================

// Clock cycles per serial bit
`define MCALC_CLKS_PER_BIT 16

// ==================================================
// Matrix slot store
// ==================================================

// Number of slots and width of a slot id
`define MCALC_NUM_SLOTS 4
`define MCALC_SLOT_W 2

// Largest row or column count, and width of a dimension or index (holds 0 to 4)
`define MCALC_MAX_DIM 4
`define MCALC_DIM_W 3

`endif
